// File: Makefile
.PHONY: build run clean

build:
	verilator --binary --timing --assert --top-module tb_ex_top -f compile.f

run: build
	./obj_dir/Vtb_ex_top | tee /dev/stderr | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+.
ex_ops_pkg.sv
ex_types_pkg.sv
ex_alu.sv
ex_store_align.sv
ex_stage.sv
ex_out_queue.sv
ex_top.sv
tb_ex_top.sv

// File: ex_alu.sv
// execute ALU with CSR update

`include "ex_cfg.svh"

module ex_alu (
  input  ex_types_pkg::ds_to_es_t i_bus,
  output ex_types_pkg::word_t     o_alu_result,
  output ex_types_pkg::word_t     o_csr_result
);

  import ex_ops_pkg::*;
  import ex_types_pkg::*;

  localparam int HALF_WD  = `EX_WORD_WD / 2;
  localparam int SHAMT_WD = $clog2(`EX_WORD_WD);

  word_t               alu_src1;
  word_t               alu_src2;
  logic [SHAMT_WD-1:0] shamt;
  logic [SHAMT_WD-2:0] shamt_w;      // word ops shift by 5 bits
  word_t               full_result;
  logic [HALF_WD-1:0]  word_result;
  gpr_addr_t           csr_uimm;
  word_t               csr_src;

  always_comb begin
    case (i_bus.src1_sel)
      SRC1_PC: alu_src1 = i_bus.pc;  // auipc, jal
      default: alu_src1 = i_bus.rs1_data;
    endcase
  end

  always_comb begin
    case (i_bus.src2_sel)
      SRC2_RS2:  alu_src2 = i_bus.rs2_data;
      SRC2_IMM:  alu_src2 = i_bus.imm;
      SRC2_FOUR: alu_src2 = word_t'(4);
      default:   alu_src2 = '0;
    endcase
  end

  assign shamt   = alu_src2[SHAMT_WD-1:0];
  assign shamt_w = alu_src2[SHAMT_WD-2:0];

  // full width result
  always_comb begin
    case (i_bus.alu_op)
      ALU_ADD:       full_result = alu_src1 + alu_src2;
      ALU_SUB:       full_result = alu_src1 - alu_src2;
      ALU_SLL:       full_result = alu_src1 << shamt;
      ALU_SLT:       full_result = word_t'($signed(alu_src1) < $signed(alu_src2));
      ALU_SLTU:      full_result = word_t'(alu_src1 < alu_src2);
      ALU_XOR:       full_result = alu_src1 ^ alu_src2;
      ALU_SRL:       full_result = alu_src1 >> shamt;
      ALU_SRA:       full_result = $signed(alu_src1) >>> shamt;
      ALU_OR:        full_result = alu_src1 | alu_src2;
      ALU_AND:       full_result = alu_src1 & alu_src2;
      ALU_PASS_SRC2: full_result = alu_src2;
      default:       full_result = '0;
    endcase
  end

  // right shifts must see only the low word, the rest truncates cleanly
  always_comb begin
    case (i_bus.alu_op)
      ALU_SLL: word_result = alu_src1[HALF_WD-1:0] << shamt_w;
      ALU_SRL: word_result = alu_src1[HALF_WD-1:0] >> shamt_w;
      ALU_SRA: word_result = $signed(alu_src1[HALF_WD-1:0]) >>> shamt_w;
      default: word_result = full_result[HALF_WD-1:0];
    endcase
  end

  assign o_alu_result = i_bus.word_cut ? {{HALF_WD{word_result[HALF_WD-1]}}, word_result}
                                       : full_result;

  // uimm sits in the rs1 field of the i forms
  assign csr_uimm = i_bus.imm[`EX_GPR_ADDR_WD-1:0];

  always_comb begin
    case (i_bus.csr_op)
      CSR_RWI, CSR_RSI, CSR_RCI: csr_src = word_t'(csr_uimm);  // zero-extended
      default:                   csr_src = i_bus.rs1_data;
    endcase
  end

  // new csr value
  always_comb begin
    case (i_bus.csr_op)
      CSR_RW, CSR_RWI: o_csr_result = csr_src;
      CSR_RS, CSR_RSI: o_csr_result = i_bus.csr_rdata | csr_src;
      CSR_RC, CSR_RCI: o_csr_result = i_bus.csr_rdata & ~csr_src;
      default:         o_csr_result = i_bus.csr_rdata;  // no csr op, old value
    endcase
  end

endmodule

// File: ex_cfg.svh
// execute stage configuration

`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data path
`define EX_WORD_WD      64                // gpr, csr and pc word
`define EX_WMASK_WD     (`EX_WORD_WD / 8) // one enable per byte lane

// register file and csr addressing
`define EX_GPR_ADDR_WD  5
`define EX_CSR_ADDR_WD  12

// output queue entries
// decode side owns this many credits after reset
`define EX_QUEUE_DEPTH  2

// credits granted by the memory stage at reset
`define EX_MS_CREDITS   2

`endif

// File: ex_ops_pkg.sv
// execute stage operation encodings

package ex_ops_pkg;

  typedef enum logic [3:0] {
    ALU_ADD       = 4'd0,
    ALU_SUB       = 4'd1,
    ALU_SLL       = 4'd2,
    ALU_SLT       = 4'd3,
    ALU_SLTU      = 4'd4,
    ALU_XOR       = 4'd5,
    ALU_SRL       = 4'd6,
    ALU_SRA       = 4'd7,
    ALU_OR        = 4'd8,
    ALU_AND       = 4'd9,
    ALU_PASS_SRC2 = 4'd10  // lui style, result is operand 2
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1 = 1'b0,
    SRC1_PC  = 1'b1
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2  // link address for jal/jalr
  } src2_sel_e;

  // access size and load extension
  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_D  = 3'd3,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5,
    MEM_WU = 3'd6
  } mem_op_e;

  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_RWI  = 3'd4,
    CSR_RSI  = 3'd5,
    CSR_RCI  = 3'd6
  } csr_op_e;

endpackage

// File: ex_out_queue.sv
// execute to memory stage output queue

`include "ex_cfg.svh"

module ex_out_queue (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_push,
  input  ex_types_pkg::es_to_ms_t i_bus,
  input  logic                    i_ms_credit,  // one credit per pulse
  output logic                    o_ms_valid,
  output ex_types_pkg::es_to_ms_t o_ms_bus,
  output logic                    o_ds_credit
);

  import ex_types_pkg::*;

  localparam int DEPTH  = `EX_QUEUE_DEPTH;
  localparam int PTR_WD = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WD = $clog2(`EX_MS_CREDITS + 1);

  es_to_ms_t           entries [DEPTH];
  logic [PTR_WD-1:0]   wr_ptr;
  logic [PTR_WD-1:0]   rd_ptr;
  logic [PTR_WD:0]     count;
  logic [CNT_WD-1:0]   ms_credits;
  logic                pop;

  function automatic logic [PTR_WD-1:0] next_ptr(input logic [PTR_WD-1:0] ptr);
    next_ptr = (ptr == PTR_WD'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // head leaves when the memory stage has room for it
  assign pop = (count != '0) && (ms_credits != '0);

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      entries[wr_ptr] <= i_bus;
    end
    if (pop) begin
      o_ms_bus <= entries[rd_ptr];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
    end
  end

  // occupancy
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count <= '0;
    end else if (i_push && !pop) begin
      count <= count + 1'b1;
    end else if (!i_push && pop) begin
      count <= count - 1'b1;
    end
  end

  // send and returned credit in one cycle cancel out
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ms_credits <= CNT_WD'(`EX_MS_CREDITS);
    end else if (pop && !i_ms_credit) begin
      ms_credits <= ms_credits - 1'b1;
    end else if (!pop && i_ms_credit) begin
      ms_credits <= ms_credits + 1'b1;
    end
  end

  // freed slot goes back to decode with the send
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ms_valid  <= 1'b0;
      o_ds_credit <= 1'b0;
    end else begin
      o_ms_valid  <= pop;
      o_ds_credit <= pop;
    end
  end

endmodule

// File: ex_stage.sv
// execute stage

module ex_stage (
  input  logic                    i_valid,
  input  ex_types_pkg::ds_to_es_t i_bus,
  output ex_types_pkg::es_to_ms_t o_bus,
  // data sram request, issued in ex
  output logic                    o_sram_ren,
  output logic                    o_sram_wen,
  output ex_types_pkg::word_t     o_sram_addr,
  output ex_types_pkg::wmask_t    o_sram_wmask,
  output ex_types_pkg::word_t     o_sram_wdata
);

  import ex_types_pkg::*;

  word_t alu_result;
  word_t csr_result;

  ex_alu u_alu (
    .i_bus        (i_bus),
    .o_alu_result (alu_result),
    .o_csr_result (csr_result)
  );

  ex_store_align u_store_align (
    .i_mem_op   (i_bus.mem_op),
    .i_addr_low (byte_off_t'(alu_result)),  // rs1 + imm
    .i_data     (i_bus.rs2_data),
    .o_wmask    (o_sram_wmask),
    .o_wdata    (o_sram_wdata)
  );

  // load data comes back in ms
  assign o_sram_ren  = i_valid & i_bus.mem_ren;
  assign o_sram_wen  = i_valid & i_bus.mem_wen;
  assign o_sram_addr = alu_result;

  always_comb begin
    o_bus.rd         = i_bus.rd;
    o_bus.csr_addr   = i_bus.csr_addr;
    o_bus.gpr_wen    = i_bus.gpr_wen;
    o_bus.csr_wen    = i_bus.csr_wen;
    o_bus.mem_ren    = i_bus.mem_ren;
    o_bus.mem_op     = i_bus.mem_op;
    o_bus.csr_inst   = i_bus.csr_inst;
    o_bus.csr_rdata  = i_bus.csr_rdata;
    o_bus.alu_result = alu_result;
    o_bus.csr_result = csr_result;
    o_bus.ebreak     = i_bus.ebreak;   // only carried along
    o_bus.invalid    = i_bus.invalid;
  end

endmodule

// File: ex_store_align.sv
// store mask and lane alignment

`include "ex_cfg.svh"

module ex_store_align (
  input  ex_ops_pkg::mem_op_e   i_mem_op,
  input  ex_types_pkg::byte_off_t i_addr_low,
  input  ex_types_pkg::word_t   i_data,
  output ex_types_pkg::wmask_t  o_wmask,
  output ex_types_pkg::word_t   o_wdata
);

  import ex_ops_pkg::*;
  import ex_types_pkg::*;

  localparam int LANE_WD = `EX_WORD_WD / `EX_WMASK_WD;  // bits per byte lane

  wmask_t base_mask;

  // low bytes covered by the access size
  always_comb begin
    case (i_mem_op)
      MEM_B, MEM_BU: base_mask = wmask_t'(8'h01);
      MEM_H, MEM_HU: base_mask = wmask_t'(8'h03);
      MEM_W, MEM_WU: base_mask = wmask_t'(8'h0f);
      default:       base_mask = '1;  // double
    endcase
  end

  assign o_wmask = base_mask << i_addr_low;

  // move each store byte into the lane its address selects
  assign o_wdata = i_data << (int'(i_addr_low) * LANE_WD);

endmodule

// File: ex_top.sv
// execute stage top with output queue

module ex_top (
  input  logic                    i_clk,
  input  logic                    i_rst,
  // decode link
  input  logic                    i_ds_valid,
  input  ex_types_pkg::ds_to_es_t i_ds_bus,
  output logic                    o_ds_credit,
  // memory stage link
  output logic                    o_ms_valid,
  output ex_types_pkg::es_to_ms_t o_ms_bus,
  input  logic                    i_ms_credit,
  // data sram
  output logic                    o_sram_ren,
  output logic                    o_sram_wen,
  output ex_types_pkg::word_t     o_sram_addr,
  output ex_types_pkg::wmask_t    o_sram_wmask,
  output ex_types_pkg::word_t     o_sram_wdata
);

  import ex_types_pkg::*;

  es_to_ms_t es_bus;  // result of the accepted instruction

  ex_stage u_stage (
    .i_valid      (i_ds_valid),
    .i_bus        (i_ds_bus),
    .o_bus        (es_bus),
    .o_sram_ren   (o_sram_ren),
    .o_sram_wen   (o_sram_wen),
    .o_sram_addr  (o_sram_addr),
    .o_sram_wmask (o_sram_wmask),
    .o_sram_wdata (o_sram_wdata)
  );

  // decode only sends with a credit, so a push always finds a free slot
  ex_out_queue u_out_queue (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_push      (i_ds_valid),
    .i_bus       (es_bus),
    .i_ms_credit (i_ms_credit),
    .o_ms_valid  (o_ms_valid),
    .o_ms_bus    (o_ms_bus),
    .o_ds_credit (o_ds_credit)
  );

endmodule

// File: ex_types_pkg.sv
// execute stage data types and stage buses

`include "ex_cfg.svh"

package ex_types_pkg;

  typedef logic [`EX_WORD_WD-1:0]          word_t;
  typedef logic [`EX_GPR_ADDR_WD-1:0]      gpr_addr_t;
  typedef logic [`EX_CSR_ADDR_WD-1:0]      csr_addr_t;
  typedef logic [`EX_WMASK_WD-1:0]         wmask_t;
  typedef logic [$clog2(`EX_WMASK_WD)-1:0] byte_off_t;  // byte within a word

  // decode to execute
  typedef struct packed {
    word_t                  rs1_data;
    word_t                  rs2_data;
    word_t                  csr_rdata;
    word_t                  imm;
    word_t                  pc;
    gpr_addr_t              rd;
    csr_addr_t              csr_addr;
    ex_ops_pkg::src1_sel_e  src1_sel;
    ex_ops_pkg::src2_sel_e  src2_sel;
    logic                   word_cut;  // 32-bit op, sign-extend result
    ex_ops_pkg::alu_op_e    alu_op;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    ex_ops_pkg::mem_op_e    mem_op;
    logic                   csr_inst;  // rd takes the old csr value
    ex_ops_pkg::csr_op_e    csr_op;
    logic                   ebreak;
    logic                   invalid;
  } ds_to_es_t;

  // execute to memory
  typedef struct packed {
    gpr_addr_t              rd;
    csr_addr_t              csr_addr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    ex_ops_pkg::mem_op_e    mem_op;    // load extension in ms
    logic                   csr_inst;
    word_t                  csr_rdata;
    word_t                  alu_result;
    word_t                  csr_result;
    logic                   ebreak;
    logic                   invalid;
  } es_to_ms_t;

endpackage

// File: tb_ex_table.svh
// execute stage test vectors
// alu_row: name, op, word_cut, src1, src2, rs1, operand 2 value, expected alu result
// csr_row: name, csr op, rs1, expected new csr value (old value CSR_OLD, uimm 5'h15)
// mem_row: name, ren, wen, size, base, offset, expected byte mask, expected lane data

  task automatic load_table();
    alu_row("add_imm", ALU_ADD, 1'b0, SRC1_RS1, SRC2_IMM,
            64'h1000, 64'hffff_ffff_ffff_fff0, 64'h0ff0);
    alu_row("sub", ALU_SUB, 1'b0, SRC1_RS1, SRC2_RS2, 64'd5, 64'd7, 64'hffff_ffff_ffff_fffe);
    alu_row("sll", ALU_SLL, 1'b0, SRC1_RS1, SRC2_RS2, 64'd1, 64'd40, 64'h0000_0100_0000_0000);
    alu_row("srl", ALU_SRL, 1'b0, SRC1_RS1, SRC2_RS2,
            64'h8000_0000_0000_0000, 64'd4, 64'h0800_0000_0000_0000);
    alu_row("sra", ALU_SRA, 1'b0, SRC1_RS1, SRC2_RS2,
            64'h8000_0000_0000_0000, 64'd4, 64'hf800_0000_0000_0000);
    alu_row("slt", ALU_SLT, 1'b0, SRC1_RS1, SRC2_RS2, 64'hffff_ffff_ffff_ffff, 64'd1, 64'd1);
    alu_row("sltu", ALU_SLTU, 1'b0, SRC1_RS1, SRC2_RS2, 64'hffff_ffff_ffff_ffff, 64'd1, 64'd0);
    alu_row("xor", ALU_XOR, 1'b0, SRC1_RS1, SRC2_RS2,
            64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 64'hf0f0_f0f0_f0f0_f0f0);
    alu_row("or", ALU_OR, 1'b0, SRC1_RS1, SRC2_RS2,
            64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 64'hfff0_fff0_fff0_fff0);
    alu_row("and", ALU_AND, 1'b0, SRC1_RS1, SRC2_RS2,
            64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 64'h0f00_0f00_0f00_0f00);
    alu_row("pc_plus4", ALU_ADD, 1'b0, SRC1_PC, SRC2_FOUR, 64'd0, 64'd0, 64'h8000_0104);
    alu_row("lui", ALU_PASS_SRC2, 1'b0, SRC1_RS1, SRC2_IMM,
            64'd9, 64'hffff_ffff_8765_4000, 64'hffff_ffff_8765_4000);
    // upper rs1 bits must not leak into the word result
    alu_row("addw_ovf", ALU_ADD, 1'b1, SRC1_RS1, SRC2_RS2,
            64'h0000_0001_7fff_ffff, 64'd1, 64'hffff_ffff_8000_0000);
    alu_row("sraw_neg", ALU_SRA, 1'b1, SRC1_RS1, SRC2_RS2,
            64'h1234_5678_8000_0000, 64'd4, 64'hffff_ffff_f800_0000);
    alu_row("srlw", ALU_SRL, 1'b1, SRC1_RS1, SRC2_RS2,
            64'hffff_ffff_8000_0000, 64'd4, 64'h0000_0000_0800_0000);
    csr_row("csrrw", CSR_RW, 64'h0f3f, 64'h0f3f);
    csr_row("csrrs", CSR_RS, 64'h0f3f, 64'h0fff);
    csr_row("csrrc", CSR_RC, 64'h0f3f, 64'h00c0);
    csr_row("csrrwi", CSR_RWI, 64'h0f3f, 64'h0015);
    csr_row("csrrsi", CSR_RSI, 64'h0f3f, 64'h00f5);
    csr_row("csrrci", CSR_RCI, 64'h0f3f, 64'h00e0);
    mem_row("sb_off5", 1'b0, 1'b1, MEM_B, 64'h1000, 64'd5, 8'h20, 64'h6677_8800_0000_0000);
    mem_row("sh_off2", 1'b0, 1'b1, MEM_H, 64'h1000, 64'd2, 8'h0c, 64'h3344_5566_7788_0000);
    mem_row("sh_off6", 1'b0, 1'b1, MEM_H, 64'h1000, 64'd6, 8'hc0, 64'h7788_0000_0000_0000);
    mem_row("sw_off4", 1'b0, 1'b1, MEM_W, 64'h1000, 64'd4, 8'hf0, 64'h5566_7788_0000_0000);
    mem_row("sd_off0", 1'b0, 1'b1, MEM_D, 64'h1000, 64'd0, 8'hff, 64'h1122_3344_5566_7788);
    mem_row("sb_off0", 1'b0, 1'b1, MEM_B, 64'h2000, 64'd0, 8'h01, 64'h1122_3344_5566_7788);
    mem_row("lwu", 1'b1, 1'b0, MEM_WU, 64'h2000, 64'd8, 8'h00, 64'h0);
  endtask

// File: tb_ex_top.sv
// execute stage testbench

`include "ex_cfg.svh"

module tb_ex_top;
  timeunit 1ns;
  timeprecision 100ps;

  import ex_ops_pkg::*;
  import ex_types_pkg::*;

  localparam word_t PC_VAL     = 64'h0000_0000_8000_0100;
  localparam word_t CSR_OLD    = 64'h0000_0000_0000_00f0;
  localparam word_t STORE_DATA = 64'h1122_3344_5566_7788;
  localparam word_t CSR_UIMM   = 64'hffff_ffff_ffff_fff5;  // uimm field 5'h15

  logic      i_clk;
  logic      i_rst;
  logic      i_ds_valid;
  ds_to_es_t i_ds_bus;
  logic      o_ds_credit;
  logic      o_ms_valid;
  es_to_ms_t o_ms_bus;
  logic      i_ms_credit;
  logic      o_sram_ren;
  logic      o_sram_wen;
  word_t     o_sram_addr;
  wmask_t    o_sram_wmask;
  word_t     o_sram_wdata;

  string     row_name[$];
  ds_to_es_t row_bus[$];
  word_t     row_alu[$];
  word_t     row_csr[$];
  wmask_t    row_mask[$];
  word_t     row_wdata[$];
  int        fail_cnt[$];
  es_to_ms_t exp_q[$];    // scoreboard, oldest first
  int        exp_idx[$];
  int        due_q[$];    // cycles at which ms credits go back
  int        ms_avail  = `EX_MS_CREDITS;
  int        cycle     = 0;
  int        limit     = 0;
  int        done_cnt  = 0;
  int        other_err = 0;

  ex_top i_dut (.*);

  function automatic ds_to_es_t base_bus();
    ds_to_es_t b;
    b           = '0;
    b.pc        = PC_VAL;
    b.csr_rdata = CSR_OLD;
    b.csr_addr  = 12'h340;
    b.gpr_wen   = 1'b1;
    b.mem_op    = MEM_D;
    return b;
  endfunction

  task automatic push_row(input string name, input ds_to_es_t bus, input word_t alu,
                          input word_t csr, input wmask_t mask, input word_t wdata);
    int n;
    n           = row_name.size();
    bus.rd      = gpr_addr_t'(n);  // distinct rd per row exposes reordering
    bus.ebreak  = (n % 3) == 1;
    bus.invalid = (n % 3) == 2;
    row_name.push_back(name);
    row_bus.push_back(bus);
    row_alu.push_back(alu);
    row_csr.push_back(csr);
    row_mask.push_back(mask);
    row_wdata.push_back(wdata);
    fail_cnt.push_back(0);
  endtask

  task automatic alu_row(input string name, input alu_op_e op, input logic wc,
                         input src1_sel_e s1, input src2_sel_e s2,
                         input word_t a, input word_t b, input word_t exp);
    ds_to_es_t bus;
    bus          = base_bus();
    bus.alu_op   = op;
    bus.word_cut = wc;
    bus.src1_sel = s1;
    bus.src2_sel = s2;
    bus.rs1_data = a;
    // unselected source holds the inverse so a wrong select shows up
    bus.rs2_data = (s2 == SRC2_RS2) ? b : ~b;
    bus.imm      = (s2 == SRC2_IMM) ? b : ~b;
    push_row(name, bus, exp, CSR_OLD, '0, '0);
  endtask

  task automatic csr_row(input string name, input csr_op_e op, input word_t src,
                         input word_t exp);
    ds_to_es_t bus;
    bus          = base_bus();
    bus.rs1_data = src;        // rs2 stays zero, alu passes rs1
    bus.imm      = CSR_UIMM;
    bus.csr_op   = op;
    bus.csr_wen  = 1'b1;
    bus.csr_inst = 1'b1;
    push_row(name, bus, src, exp, '0, '0);
  endtask

  task automatic mem_row(input string name, input logic ren, input logic wen, input mem_op_e op,
                         input word_t base, input word_t off, input wmask_t mask,
                         input word_t wdata);
    ds_to_es_t bus;
    bus          = base_bus();
    bus.src2_sel = SRC2_IMM;
    bus.rs1_data = base;
    bus.rs2_data = STORE_DATA;
    bus.imm      = off;
    bus.mem_ren  = ren;
    bus.mem_wen  = wen;
    bus.gpr_wen  = ren;
    bus.mem_op   = op;
    push_row(name, bus, base + off, CSR_OLD, mask, wdata);
  endtask

  `include "tb_ex_table.svh"

  function automatic es_to_ms_t expect_ms(input int idx);
    es_to_ms_t e;
    ds_to_es_t b;
    b            = row_bus[idx];
    e.rd         = b.rd;
    e.csr_addr   = b.csr_addr;
    e.gpr_wen    = b.gpr_wen;
    e.csr_wen    = b.csr_wen;
    e.mem_ren    = b.mem_ren;
    e.mem_op     = b.mem_op;
    e.csr_inst   = b.csr_inst;
    e.csr_rdata  = b.csr_rdata;   // passes through untouched
    e.alu_result = row_alu[idx];
    e.csr_result = row_csr[idx];
    e.ebreak     = b.ebreak;
    e.invalid    = b.invalid;
    return e;
  endfunction

  task automatic check_val(input int idx, input string field, input word_t got,
                           input word_t exp);
    assert (got == exp) else begin
      $display("Error at %0d ns: test %0s field %0s got %h expected %h",
               $time, row_name[idx], field, got, exp);
      fail_cnt[idx]++;
    end
  endtask

  task automatic compare_result(input int idx, input es_to_ms_t exp);
    check_val(idx, "alu_result", o_ms_bus.alu_result, exp.alu_result);
    check_val(idx, "csr_result", o_ms_bus.csr_result, exp.csr_result);
    check_val(idx, "csr_rdata", o_ms_bus.csr_rdata, exp.csr_rdata);
    check_val(idx, "rd", word_t'(o_ms_bus.rd), word_t'(exp.rd));
    assert (o_ms_bus == exp) else begin
      $display("Error at %0d ns: test %0s control fields got %h expected %h",
               $time, row_name[idx], o_ms_bus, exp);
      fail_cnt[idx]++;
    end
    $display("test %0d %0s %0s", idx, row_name[idx], (fail_cnt[idx] == 0) ? "ok" : "FAILED");
    done_cnt++;
  endtask

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle++;
    if (limit != 0 && cycle >= limit) begin
      $display("timeout after %0d cycles, DUT outputs stalled", cycle);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // memory stage, credits back after 0 to 3 cycles
  initial begin : ms_model
    int idx;
    i_ms_credit = 1'b0;
    forever begin
      @(posedge i_clk);
      #1;
      i_ms_credit = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        i_ms_credit = 1'b1;
        ms_avail++;
      end
      @(negedge i_clk);
      if (!i_rst) begin
        assert (o_ds_credit == o_ms_valid) else begin
          $display("Error at %0d ns: o_ds_credit %0b but departure %0b",
                   $time, o_ds_credit, o_ms_valid);
          other_err++;
        end
        if (o_ms_valid) begin
          assert (ms_avail > 0) else begin
            $display("Error at %0d ns: result sent without a memory stage credit", $time);
            other_err++;
          end
          ms_avail--;
          due_q.push_back(cycle + int'($urandom_range(0, 3)));
          if (exp_q.size() == 0) begin
            $display("result showed up at %0d ns with nothing outstanding", $time);
            other_err++;
          end else begin
            idx = exp_idx.pop_front();
            compare_result(idx, exp_q.pop_front());
          end
        end
      end
    end
  end

  initial begin : drive
    int        ds_credits;
    int        idx;
    int        failed;
    ds_to_es_t bus;
    i_rst      = 1'b1;
    i_ds_valid = 1'b0;
    i_ds_bus   = '0;
    void'($urandom(23));
    load_table();
    limit = row_name.size() * 8 + 50;
    repeat (2) @(posedge i_clk);
    #1;
    i_rst      = 1'b0;
    ds_credits = `EX_QUEUE_DEPTH;
    idx        = 0;
    while (idx < row_name.size()) begin
      @(posedge i_clk);
      #1;
      if (o_ds_credit) ds_credits++;
      i_ds_valid = ds_credits > 0;
      bus        = row_bus[idx];
      if (i_ds_valid) begin
        i_ds_bus = bus;
        ds_credits--;
        exp_q.push_back(expect_ms(idx));
        exp_idx.push_back(idx);
      end
      @(negedge i_clk);
      if (i_ds_valid) begin
        check_val(idx, "sram addr", o_sram_addr, row_alu[idx]);
        check_val(idx, "sram ren", word_t'(o_sram_ren), word_t'(bus.mem_ren));
        check_val(idx, "sram wen", word_t'(o_sram_wen), word_t'(bus.mem_wen));
        if (bus.mem_wen) begin
          check_val(idx, "sram wmask", word_t'(o_sram_wmask), word_t'(row_mask[idx]));
          check_val(idx, "sram wdata", o_sram_wdata, row_wdata[idx]);
        end
        idx++;
      end else begin
        // bus still holds the last row, enables must stay gated
        assert (!o_sram_ren && !o_sram_wen) else begin
          $display("Error at %0d ns: sram enable high without a valid instruction", $time);
          other_err++;
        end
      end
    end
    @(posedge i_clk);
    #1;
    i_ds_valid = 1'b0;
    while (done_cnt < row_name.size()) @(posedge i_clk);
    repeat (4) @(posedge i_clk);  // any extra result would show here
    failed = 0;
    foreach (fail_cnt[i]) if (fail_cnt[i] != 0) failed++;
    $display("tests run %0d, passed %0d, failed %0d, other errors %0d",
             row_name.size(), row_name.size() - failed, failed, other_err);
    if (failed == 0 && other_err == 0 && exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
